// File: design/cachePkg.sv
package cachePkg;

  // address and data geometry
  localparam int ADDR_W   = 32;
  localparam int XLEN     = 64;

  // 64 sets of 32-byte lines
  localparam int SETS     = 64;
  localparam int INDEX_W  = 6;
  localparam int OFFSET_W = 5;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // a line is four 64-bit beats
  localparam int BEATS    = 4;
  localparam int LINE_W   = BEATS * XLEN;

  // lowest offset bit that selects a word in the line
  localparam int WORD_LSB = 3;

  // controller states
  localparam int STATE_W  = 2;
  localparam logic [STATE_W-1:0] S_IDLE    = 2'd0;
  localparam logic [STATE_W-1:0] S_COMPARE = 2'd1;
  localparam logic [STATE_W-1:0] S_REFILL  = 2'd2;
  localparam logic [STATE_W-1:0] S_RESPOND = 2'd3;

  // request address split into cache fields
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } cacheFieldsT;

  // same word seen raw or decoded
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    cacheFieldsT       f;
  } cacheAddrT;

endpackage

// File: design/wayIf.sv
interface wayIf import cachePkg::*; ();

  // index and tag serve both lookups and fills
  logic                lookupEn;
  logic [INDEX_W-1:0]  index;
  logic [TAG_W-1:0]    tag;

  // line write after a refill
  logic                fillEn;
  logic [LINE_W-1:0]   fillLine;

  // lookup results, one cycle after lookupEn
  logic                hit;
  logic                lineValid;
  logic [LINE_W-1:0]   rdLine;

  modport ctrl (
    output lookupEn, index, tag, fillEn, fillLine,
    input  hit, lineValid, rdLine
  );

  modport way (
    input  lookupEn, index, tag, fillEn, fillLine,
    output hit, lineValid, rdLine
  );

endinterface

// File: design/cacheWay.sv
module cacheWay import cachePkg::*; (
  input  logic clk,
  input  logic rst_n,
  wayIf.way    wayBus
);

  // tag and line storage
  logic [TAG_W-1:0]  tagArr  [SETS];
  logic [LINE_W-1:0] lineArr [SETS];
  logic [SETS-1:0]   validArr;

  // lookup pipeline registers
  logic [TAG_W-1:0]  storedTagQ;
  logic [TAG_W-1:0]  reqTagQ;
  logic              validQ;
  logic [LINE_W-1:0] lineQ;

  // valid bit set by a fill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
    end else if (wayBus.fillEn) begin
      validArr[wayBus.index] <= 1'b1;
    end
  end

  // tag and line write on a fill
  always_ff @(posedge clk) begin
    if (wayBus.fillEn) begin
      tagArr[wayBus.index]  <= wayBus.tag;
      lineArr[wayBus.index] <= wayBus.fillLine;
    end
  end

  // registered valid from the lookup
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= 1'b0;
    end else if (wayBus.lookupEn) begin
      validQ <= validArr[wayBus.index];
    end
  end

  // stored tag, requested tag and line from the lookup
  always_ff @(posedge clk) begin
    if (wayBus.lookupEn) begin
      storedTagQ <= tagArr[wayBus.index];
      reqTagQ    <= wayBus.tag;
      lineQ      <= lineArr[wayBus.index];
    end
  end

  // compare happens in the cycle after the lookup
  assign wayBus.hit       = validQ && (storedTagQ == reqTagQ);
  assign wayBus.lineValid = validQ;
  assign wayBus.rdLine    = lineQ;

endmodule

// File: design/lineFill.sv
module lineFill import cachePkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  cacheAddrT         lineAddr_i,
  input  logic              rdValid_i,
  input  logic              rdLast_i,
  input  logic [XLEN-1:0]   rdData_i,
  output logic              cacheRdValid_o,
  output logic [ADDR_W-1:0] cacheAddr_o,
  output logic              done_o,
  output logic [LINE_W-1:0] line_o
);

  logic [$clog2(BEATS)-1:0] beatCnt;
  logic                     beatTaken;
  logic                     lastBeat;

  // beats only count while the read is outstanding
  assign beatTaken = cacheRdValid_o && rdValid_i;
  // fourth beat ends the burst even without rdLast
  assign lastBeat  = rdLast_i || (beatCnt == BEATS - 1);

  // read request, beat count and completion pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cacheRdValid_o <= 1'b0;
      done_o         <= 1'b0;
      beatCnt        <= '0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        cacheRdValid_o <= 1'b1;
        beatCnt        <= '0;
      end else if (beatTaken) begin
        beatCnt <= beatCnt + 1'b1;
        if (lastBeat) begin
          cacheRdValid_o <= 1'b0;
          done_o         <= 1'b1;
        end
      end
    end
  end

  // line-aligned address held for the whole burst
  always_ff @(posedge clk) begin
    if (start_i) begin
      cacheAddr_o <= {lineAddr_i.f.tag, lineAddr_i.f.index, {OFFSET_W{1'b0}}};
    end
  end

  // shift right so beat 0 lands in bits 63:0
  always_ff @(posedge clk) begin
    if (beatTaken) begin
      line_o <= {rdData_i, line_o[LINE_W-1:XLEN]};
    end
  end

endmodule

// File: design/cacheCtrl.sv
module cacheCtrl import cachePkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // pipeline side
  input  logic              valid_i,
  input  logic [ADDR_W-1:0] addr_i,
  output logic              addrOk_o,
  output logic              dataOk_o,
  output logic [XLEN-1:0]   rdData_o,
  // way lookups
  wayIf.ctrl                way0,
  wayIf.ctrl                way1,
  // memory side
  output logic              cacheRdValid_o,
  output logic [ADDR_W-1:0] cacheAddr_o,
  input  logic              rdValid_i,
  input  logic              rdLast_i,
  input  logic [XLEN-1:0]   rdData_i
);

  logic [STATE_W-1:0] state;
  logic [STATE_W-1:0] nextState;
  logic               idleEn;
  logic               compareEn;
  logic               refillEn;
  logic               cacheHit;
  logic               missStart;
  logic               fillDone;
  logic               fillWrite;
  cacheAddrT          inAddr;
  cacheAddrT          req;
  logic [SETS-1:0]    lru;
  logic               victimSel;
  logic               victim;
  logic [LINE_W-1:0]  hitLine;
  logic [LINE_W-1:0]  fillLine;
  logic [OFFSET_W-WORD_LSB-1:0] wordSel;

  function automatic logic [XLEN-1:0] pickWord(input logic [LINE_W-1:0] line,
                                               input logic [OFFSET_W-WORD_LSB-1:0] sel);
    return line[sel*XLEN +: XLEN];
  endfunction

  assign idleEn    = (state == S_IDLE);
  assign compareEn = (state == S_COMPARE);
  assign refillEn  = (state == S_REFILL);

  assign cacheHit  = way0.hit || way1.hit;
  assign missStart = compareEn && !cacheHit;
  assign fillWrite = refillEn && fillDone;

  // take a request when idle or behind a hit
  assign addrOk_o  = valid_i && (idleEn || (compareEn && cacheHit));

  assign inAddr.raw = addr_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      S_IDLE:    if (valid_i) nextState = S_COMPARE;
      S_COMPARE: begin
        if (!cacheHit) begin
          nextState = S_REFILL;
        end else if (!valid_i) begin
          nextState = S_IDLE;
        end
      end
      S_REFILL:  if (fillDone) nextState = S_RESPOND;
      default:   nextState = S_IDLE;
    endcase
  end

  // request latched as a raw word
  always_ff @(posedge clk) begin
    if (addrOk_o) begin
      req.raw <= addr_i;
    end
  end

  // lookups come from the incoming address, fills from the latched one
  assign way0.lookupEn = addrOk_o;
  assign way1.lookupEn = addrOk_o;
  assign way0.index    = refillEn ? req.f.index : inAddr.f.index;
  assign way1.index    = refillEn ? req.f.index : inAddr.f.index;
  assign way0.tag      = refillEn ? req.f.tag : inAddr.f.tag;
  assign way1.tag      = refillEn ? req.f.tag : inAddr.f.tag;
  assign way0.fillEn   = fillWrite && !victim;
  assign way1.fillEn   = fillWrite && victim;
  assign way0.fillLine = fillLine;
  assign way1.fillLine = fillLine;

  // first invalid way wins, else the LRU pointer
  always_comb begin
    if (!way0.lineValid) begin
      victimSel = 1'b0;
    end else if (!way1.lineValid) begin
      victimSel = 1'b1;
    end else begin
      victimSel = lru[req.f.index];
    end
  end

  // LRU points at the way to replace next
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lru    <= '0;
      victim <= 1'b0;
    end else begin
      if (compareEn && cacheHit) begin
        lru[req.f.index] <= way0.hit;
      end
      if (missStart) begin
        victim <= victimSel;
      end
      if (fillWrite) begin
        lru[req.f.index] <= !victim;
      end
    end
  end

  lineFill lineFill_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (missStart),
    .lineAddr_i     (req),
    .rdValid_i      (rdValid_i),
    .rdLast_i       (rdLast_i),
    .rdData_i       (rdData_i),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheAddr_o    (cacheAddr_o),
    .done_o         (fillDone),
    .line_o         (fillLine)
  );

  // word select from the hitting way
  assign hitLine = way0.hit ? way0.rdLine : way1.rdLine;
  assign wordSel = req.f.offset[OFFSET_W-1:WORD_LSB];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dataOk_o <= 1'b0;
    end else begin
      dataOk_o <= (compareEn && cacheHit) || fillWrite;
    end
  end

  always_ff @(posedge clk) begin
    if (compareEn && cacheHit) begin
      rdData_o <= pickWord(hitLine, wordSel);
    end else if (fillWrite) begin
      rdData_o <= pickWord(fillLine, wordSel);
    end
  end

endmodule

// File: design/cacheTop.sv
module cacheTop import cachePkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // pipeline
  input  logic              valid_i,
  input  logic [ADDR_W-1:0] addr_i,
  output logic              addrOk_o,
  output logic              dataOk_o,
  output logic [XLEN-1:0]   rdData_o,
  // memory
  output logic              cacheRdValid_o,
  output logic [ADDR_W-1:0] cacheAddr_o,
  input  logic              rdValid_i,
  input  logic              rdLast_i,
  input  logic [XLEN-1:0]   rdData_i
);

  // one bus per way
  wayIf wayIf0 ();
  wayIf wayIf1 ();

  cacheCtrl cacheCtrl_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .addr_i         (addr_i),
    .addrOk_o       (addrOk_o),
    .dataOk_o       (dataOk_o),
    .rdData_o       (rdData_o),
    .way0           (wayIf0.ctrl),
    .way1           (wayIf1.ctrl),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheAddr_o    (cacheAddr_o),
    .rdValid_i      (rdValid_i),
    .rdLast_i       (rdLast_i),
    .rdData_i       (rdData_i)
  );

  cacheWay way0_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .wayBus (wayIf0.way)
  );

  cacheWay way1_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .wayBus (wayIf1.way)
  );

endmodule

// File: verification/cacheCtrl_sva.sv
module cacheCtrl_sva import cachePkg::*; (
  input logic               clk,
  input logic               rst_n,
  input logic               hit0_i,
  input logic               hit1_i,
  input logic               addrOk_i,
  input logic               dataOk_i,
  input logic               cacheRdValid_i,
  input logic [ADDR_W-1:0]  cacheAddr_i
);

  // a tag lives in one way only
  oneHit: assert property (@(posedge clk) disable iff (!rst_n) !(hit0_i && hit1_i))
    else $error("both ways report a hit");

  noRespDuringRead: assert property (@(posedge clk) disable iff (!rst_n)
    !(dataOk_i && cacheRdValid_i))
    else $error("dataOk_o high while a memory read is open");

  // burst address held until the last beat
  addrStable: assert property (@(posedge clk) disable iff (!rst_n)
    $past(cacheRdValid_i) && cacheRdValid_i |-> $stable(cacheAddr_i))
    else $error("cacheAddr_o changed during a read burst");

  // no request enters while the line is being read
  noTakeInRefill: assert property (@(posedge clk) disable iff (!rst_n)
    cacheRdValid_i |-> !addrOk_i)
    else $error("request taken during a refill read");

endmodule

bind cacheCtrl cacheCtrl_sva ctrlSva_i (
  .clk            (clk),
  .rst_n          (rst_n),
  .hit0_i         (way0.hit),
  .hit1_i         (way1.hit),
  .addrOk_i       (addrOk_o),
  .dataOk_i       (dataOk_o),
  .cacheRdValid_i (cacheRdValid_o),
  .cacheAddr_i    (cacheAddr_o)
);

// File: verification/cacheTb.sv
module cacheTb import cachePkg::*; ();

  localparam int NUM_REQ    = 400;
  localparam int MAX_CYCLES = NUM_REQ * 24;

  logic              clk;
  logic              rst_n;
  logic              valid_i;
  logic [ADDR_W-1:0] addr_i;
  logic              addrOk_o;
  logic              dataOk_o;
  logic [XLEN-1:0]   rdData_o;
  logic              cacheRdValid_o;
  logic [ADDR_W-1:0] cacheAddr_o;
  logic              rdValid_i;
  logic              rdLast_i;
  logic [XLEN-1:0]   rdData_i;

  integer seed;
  int     cycle;
  int     accepted;
  int     responded;
  int     beatIdx;
  int     gap;
  int     beatsSent;
  int     missesDone;
  int     missCheck;
  logic [ADDR_W-1:0] missAddr;
  logic              missOpen;

  // expected responses in acceptance order
  logic [ADDR_W-1:0] expAddr  [$];
  logic              expHit   [$];
  int                expCycle [$];

  // reference cache state per set
  logic [TAG_W-1:0] mTag   [SETS][2];
  logic             mValid [SETS][2];
  logic             mLru   [SETS];

  // 3 tags over 4 sets overflow the two ways of a set
  logic [TAG_W-1:0]   tagTab [3] = '{21'h00012, 21'h0a5c3, 21'h1f00f};
  logic [INDEX_W-1:0] setTab [4] = '{6'd0, 6'd5, 6'd17, 6'd63};

  cacheTop cacheTop_i (.*);

  always #5 clk = ~clk;

  // memory word is the address low and its inverse high
  function automatic logic [XLEN-1:0] memWord(input logic [ADDR_W-1:0] a);
    return {~a, a};
  endfunction

  // returns the hit and updates tags, valid bits and LRU
  function automatic logic modelAccess(input logic [ADDR_W-1:0] a);
    logic [TAG_W-1:0]   t;
    logic [INDEX_W-1:0] s;
    int                 w;
    t = a[ADDR_W-1 -: TAG_W];
    s = a[OFFSET_W +: INDEX_W];
    for (int i = 0; i < 2; i++) begin
      if (mValid[s][i] && mTag[s][i] == t) begin
        mLru[s] = (i == 0);
        return 1'b1;
      end
    end
    // first invalid way, else the LRU pointer
    if (!mValid[s][0]) w = 0;
    else if (!mValid[s][1]) w = 1;
    else w = int'(mLru[s]);
    mValid[s][w] = 1'b1;
    mTag[s][w]   = t;
    mLru[s]      = (w == 0);
    return 1'b0;
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic reportMismatch(input string name, input logic [XLEN-1:0] expV,
                                input logic [XLEN-1:0] actV);
    $display("CHECK FAILED %s expected=%h actual=%h", name, expV, actV);
    abortRun("value mismatch");
  endtask

  initial begin
    logic [31:0]     r;
    logic            took;
    logic            missResp;
    logic            expTake;
    logic [XLEN-1:0] expWord;
    seed = 32'h1eeb;
    clk = 1'b0;
    rst_n = 1'b0;
    valid_i = 1'b0;
    addr_i = '0;
    rdValid_i = 1'b0;
    rdLast_i = 1'b0;
    rdData_i = '0;
    cycle = 0;
    accepted = 0;
    responded = 0;
    beatIdx = 0;
    gap = 0;
    beatsSent = 0;
    missesDone = 0;
    missCheck = -1;
    missAddr = '0;
    missOpen = 1'b0;
    took = 1'b0;
    for (int s = 0; s < SETS; s++) begin
      mValid[s][0] = 1'b0;
      mValid[s][1] = 1'b0;
      mLru[s] = 1'b0;
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    assert (!addrOk_o && !dataOk_o && !cacheRdValid_o)
      else abortRun("outputs not idle after reset");
    while (responded < NUM_REQ) begin
      @(negedge clk);
      cycle++;
      missResp = 1'b0;
      if (cycle > MAX_CYCLES) abortRun("timeout, responses stopped coming");
      // a predicted miss must open a burst for its line
      if (cycle == missCheck) begin
        assert (cacheRdValid_o) else abortRun("no memory read after a predicted miss");
        assert (cacheAddr_o == {missAddr[ADDR_W-1:OFFSET_W], 5'b0})
          else reportMismatch("missAddress", XLEN'(missAddr), XLEN'(cacheAddr_o));
      end
      if (dataOk_o) begin
        assert (expAddr.size() > 0) else abortRun("dataOk_o with no request outstanding");
        expWord = memWord({expAddr[0][ADDR_W-1:3], 3'b000});
        assert (rdData_o == expWord) else reportMismatch("readData", expWord, rdData_o);
        if (expHit[0]) begin
          assert (cycle == expCycle[0] + 2)
            else reportMismatch("hitLatency", XLEN'(expCycle[0] + 2), XLEN'(cycle));
          assert (!cacheRdValid_o) else abortRun("memory read during a hit response");
        end else begin
          missesDone++;
          missResp = 1'b1;
          assert (beatsSent == BEATS * missesDone)
            else reportMismatch("missBeats", XLEN'(BEATS * missesDone), XLEN'(beatsSent));
        end
        void'(expAddr.pop_front());
        void'(expHit.pop_front());
        void'(expCycle.pop_front());
        responded++;
      end
      // memory responder with random gaps between beats
      rdValid_i = 1'b0;
      rdLast_i  = 1'b0;
      if (!cacheRdValid_o) begin
        beatIdx = 0;
      end else if (gap > 0) begin
        gap--;
      end else if (beatIdx < BEATS) begin
        rdValid_i = 1'b1;
        rdLast_i  = (beatIdx == BEATS - 1);
        rdData_i  = memWord(cacheAddr_o + ADDR_W'(8 * beatIdx));
        beatIdx++;
        beatsSent++;
        gap = $unsigned($random(seed)) % 4;
      end
      // request held until taken
      if (took || !valid_i) begin
        r = $random(seed);
        valid_i = (accepted < NUM_REQ) && (r[15:14] != 2'b00);
        addr_i  = {tagTab[r[7:0] % 3], setTab[r[9:8]], r[11:10], 3'b000};
      end
      #1;
      // requests are taken when idle or behind a hit but not during a miss
      expTake = valid_i && !missOpen;
      assert (addrOk_o == expTake)
        else reportMismatch("addrOk", XLEN'(expTake), XLEN'(addrOk_o));
      if (missResp) missOpen = 1'b0;
      took = valid_i && addrOk_o;
      if (took) begin
        expAddr.push_back(addr_i);
        expHit.push_back(modelAccess(addr_i));
        expCycle.push_back(cycle);
        if (!expHit[$]) begin
          missAddr  = addr_i;
          missCheck = cycle + 2;
          missOpen  = 1'b1;
        end
        accepted++;
      end
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: all.f
design/cachePkg.sv
design/wayIf.sv
design/cacheWay.sv
design/lineFill.sv
design/cacheCtrl.sv
design/cacheTop.sv
verification/cacheCtrl_sva.sv
verification/cacheTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cacheTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation did not pass, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
